//--- tb.f
+incdir+verilog
verilog/mipsPkg.sv
verilog/instrDecoder.sv
verilog/regFile.sv
verilog/fetchUnit.sv
verilog/executeStage.sv
verilog/memWbStage.sv
verilog/hazardForward.sv
verilog/mipsCpu.sv
tests/mipsCpuTb.sv

//--- Makefile
VERILATOR  ?= verilator
FLAGS      := --binary --timing
LINT_FLAGS := --lint-only -Wall --timing
TOP        := mipsCpuTb
FILELIST   := tb.f
BUILD_DIR  := obj_dir
PASS_TEXT  := RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# Pass only when the pass line appears in the simulation output
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

//--- tests/mipsCpuTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "mipsDefines.svh"

module mipsCpuTb;
    import mipsPkg::*;

    localparam wordT ResetPc      = `MIPS_RESET_PC;
    localparam int ProgLen        = 64;
    localparam int ClkPeriod      = 8;
    localparam int ResetCycles    = 10;
    localparam int DrainCycles    = 8;
    localparam int WatchdogCycles = ProgLen * 8 + ResetCycles;

    // Error counter index per kind of expected write
    localparam int KindAlu  = 1;
    localparam int KindLoad = 2;
    localparam int KindJal  = 3;

    logic       clk;
    logic       rstN;
    wordT       instrAddr;
    wordT       instrRdata;
    wordT       dataAddr;
    wordT       dataWdata;
    wordT       dataPc;
    logic [3:0] dataByteen;
    wordT       dataRdata;
    logic       regWriteEn;
    regAddrT    regWriteAddr;
    wordT       regWriteData;
    wordT       regWritePc;

    integer seed;
    wordT   prog [ProgLen];
    wordT   dmem [64];
    wordT   modelMem [64];
    wordT   modelRegs [32];

    // Expected retirements in program order
    wordT    expWrPc[$];
    regAddrT expWrAddr[$];
    wordT    expWrData[$];
    int      expWrKind[$];
    wordT    expStPc[$];
    wordT    expStAddr[$];
    wordT    expStData[$];

    int errs [5];
    int checks;
    int seenWrites;
    int seenStores;
    int nExpWrites;
    int nExpStores;
    int nTaken;
    int nUntaken;
    int nJal;

    mipsCpu u_mipsCpu (
        .clk(clk), .rstN(rstN),
        .instrAddr(instrAddr), .instrRdata(instrRdata),
        .dataAddr(dataAddr), .dataWdata(dataWdata), .dataPc(dataPc),
        .dataByteen(dataByteen), .dataRdata(dataRdata),
        .regWriteEn(regWriteEn), .regWriteAddr(regWriteAddr),
        .regWriteData(regWriteData), .regWritePc(regWritePc)
    );

    // Program sits in one 256-byte page, nops elsewhere
    assign instrRdata = (instrAddr[31:8] == ResetPc[31:8]) ? prog[instrAddr[7:2]] : '0;
    assign dataRdata  = dmem[dataAddr[7:2]];

    always @(posedge clk) begin
        if (dataByteen != 4'h0) begin
            dmem[dataAddr[7:2]] <= dataWdata;
        end
    end

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    function automatic int randBelow(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // Small register set so that dependences are frequent
    function automatic regAddrT randReg();
        int v;
        v = randBelow(8);
        return (v == 7) ? 5'd31 : v[4:0];
    endfunction

    function automatic wordT fillWord(input int idx);
        return (wordT'(idx) * 32'h0101_0101) ^ 32'hC0DE_0000 ^ (wordT'(idx) << 26);
    endfunction

    task automatic genProgram();
        int          i;
        int          kind;
        int          tgt;
        logic        prevCtl;
        regAddrT     rs;
        regAddrT     rt;
        regAddrT     rd;
        logic [15:0] imm;
        logic [5:0]  fn;
        prevCtl = 1'b0;
        for (i = 0; i < ProgLen; i++) begin
            kind = randBelow(16);
            rs   = randReg();
            rt   = randReg();
            rd   = randReg();
            imm  = 16'(randBelow(65536));
            tgt  = 0;
            // No control transfer in a delay slot, targets strictly forward
            if (kind >= 11 && kind <= 14) begin
                if (prevCtl || i > ProgLen - 3) begin
                    kind = 0;
                end else begin
                    tgt = i + 2 + randBelow(ProgLen - i - 2);
                end
            end
            prevCtl = (kind >= 11 && kind <= 14);
            case (kind)
                4, 5:    prog[6'(i)] = {`MIPS_OP_ORI, rs, rt, imm};
                6:       prog[6'(i)] = {`MIPS_OP_LUI, 5'd0, rt, imm};
                7, 8:    prog[6'(i)] = {`MIPS_OP_LW, 5'd0, rt, 8'd0, imm[5:0], 2'b00};
                9, 10:   prog[6'(i)] = {`MIPS_OP_SW, 5'd0, rt, 8'd0, imm[5:0], 2'b00};
                11, 12:  prog[6'(i)] = {`MIPS_OP_BEQ, rs, (imm[15] ? rs : rt), 16'(tgt - i - 1)};
                13:      prog[6'(i)] = {`MIPS_OP_BNE, rs, rt, 16'(tgt - i - 1)};
                14:      prog[6'(i)] = {`MIPS_OP_JAL, 26'((ResetPc >> 2) + wordT'(tgt))};
                default: begin
                    case (randBelow(4))
                        0:       fn = `MIPS_FN_ADDU;
                        1:       fn = `MIPS_FN_SUBU;
                        2:       fn = `MIPS_FN_OR;
                        default: fn = `MIPS_FN_SLT;
                    endcase
                    prog[6'(i)] = {`MIPS_OP_SPECIAL, rs, rt, rd, 5'd0, fn};
                end
            endcase
        end
    endtask

    // Instruction-level model, one delay slot after each branch and jal
    task automatic runModel();
        wordT    pc;
        wordT    nextPc;
        wordT    newNext;
        wordT    w;
        wordT    a;
        wordT    b;
        wordT    res;
        wordT    imm;
        regAddrT dst;
        logic    wr;
        logic    taken;
        int      kind;
        pc     = ResetPc;
        nextPc = ResetPc + 32'd4;
        while (pc[31:8] == ResetPc[31:8]) begin
            w       = prog[pc[7:2]];
            a       = modelRegs[w[25:21]];
            b       = modelRegs[w[20:16]];
            imm     = {{16{w[15]}}, w[15:0]};
            newNext = nextPc + 32'd4;
            wr      = 1'b0;
            dst     = w[20:16];
            kind    = KindAlu;
            res     = '0;
            case (w[31:26])
                `MIPS_OP_SPECIAL: begin
                    wr  = 1'b1;
                    dst = w[15:11];
                    case (w[5:0])
                        `MIPS_FN_ADDU: res = a + b;
                        `MIPS_FN_SUBU: res = a - b;
                        `MIPS_FN_OR:   res = a | b;
                        `MIPS_FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default:       wr = 1'b0;
                    endcase
                end
                `MIPS_OP_ORI: begin
                    wr  = 1'b1;
                    res = a | {16'b0, w[15:0]};
                end
                `MIPS_OP_LUI: begin
                    wr  = 1'b1;
                    res = {w[15:0], 16'b0};
                end
                `MIPS_OP_LW: begin
                    wr   = 1'b1;
                    kind = KindLoad;
                    res  = modelMem[(a + imm) >> 2 & 32'd63];
                end
                `MIPS_OP_SW: begin
                    expStPc.push_back(pc);
                    expStAddr.push_back(a + imm);
                    expStData.push_back(b);
                    modelMem[(a + imm) >> 2 & 32'd63] = b;
                end
                `MIPS_OP_BEQ, `MIPS_OP_BNE: begin
                    taken = (a == b) != (w[31:26] == `MIPS_OP_BNE);
                    if (taken) begin
                        newNext = nextPc + (imm << 2);
                        nTaken++;
                    end else begin
                        nUntaken++;
                    end
                end
                `MIPS_OP_JAL: begin
                    wr      = 1'b1;
                    dst     = `MIPS_LINK_REG;
                    kind    = KindJal;
                    res     = pc + 32'd8;
                    newNext = {nextPc[31:28], w[25:0], 2'b00};
                    nJal++;
                end
                default: ;
            endcase
            if (wr && dst != '0) begin
                modelRegs[dst] = res;
                expWrPc.push_back(pc);
                expWrAddr.push_back(dst);
                expWrData.push_back(res);
                expWrKind.push_back(kind);
            end
            pc     = nextPc;
            nextPc = newNext;
        end
    endtask

    task automatic checkIdle(input wordT gotAddr, input logic gotEn, input logic [3:0] gotBe);
        checks++;
        if (gotAddr !== ResetPc || gotEn !== 1'b0 || gotBe !== 4'h0) begin
            $display("Error at %0t: reset state instrAddr=%h regWriteEn=%b dataByteen=%h",
                     $time, gotAddr, gotEn, gotBe);
            errs[0]++;
        end
    endtask

    task automatic checkRegWrite(input int kind, input wordT expPc, input regAddrT expAddr,
                                 input wordT expData, input wordT gotPc,
                                 input regAddrT gotAddr, input wordT gotData);
        checks++;
        if (gotPc !== expPc) begin
            $display("Error at %0t: write from pc %h, expected pc %h", $time, gotPc, expPc);
            errs[3]++;
        end else if (gotAddr !== expAddr || gotData !== expData) begin
            $display("Error at %0t: pc %h wrote r%0d=%h, expected r%0d=%h",
                     $time, gotPc, gotAddr, gotData, expAddr, expData);
            errs[3'(kind)]++;
        end
    endtask

    task automatic checkStore(input wordT expPc, input wordT expAddr, input wordT expData,
                              input wordT gotPc, input wordT gotAddr, input wordT gotData,
                              input logic [3:0] gotBe);
        checks++;
        if (gotPc !== expPc || gotAddr !== expAddr || gotData !== expData || gotBe !== 4'hf) begin
            $display("Error at %0t: store pc %h [%h]=%h be %h, expected pc %h [%h]=%h",
                     $time, gotPc, gotAddr, gotData, gotBe, expPc, expAddr, expData);
            errs[2]++;
        end
    endtask

    task automatic reportTest(input int idx, input string name);
        $display("test %0d %s: %s (%0d errors)", idx + 1, name,
                 (errs[3'(idx)] == 0) ? "ok" : "failed", errs[3'(idx)]);
    endtask

    // Outputs are stable at the falling edge
    always @(negedge clk) begin
        if (rstN && regWriteEn) begin
            seenWrites++;
            if (expWrPc.size() == 0) begin
                $display("unexpected register write to r%0d from pc %h", regWriteAddr, regWritePc);
                errs[3]++;
            end else begin
                checkRegWrite(expWrKind.pop_front(), expWrPc.pop_front(), expWrAddr.pop_front(),
                              expWrData.pop_front(), regWritePc, regWriteAddr, regWriteData);
            end
        end
        if (rstN && dataByteen != 4'h0) begin
            seenStores++;
            if (expStPc.size() == 0) begin
                $display("unexpected store to address %h from pc %h", dataAddr, dataPc);
                errs[2]++;
            end else begin
                checkStore(expStPc.pop_front(), expStAddr.pop_front(), expStData.pop_front(),
                           dataPc, dataAddr, dataWdata, dataByteen);
            end
        end
    end

    initial begin
        #(WatchdogCycles * ClkPeriod);
        $display("timeout: retirements missing");
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        int i;
        int total;
        seed = 76;
        rstN = 1'b0;
        for (i = 0; i < 64; i++) begin
            dmem[6'(i)]     <= fillWord(i);
            modelMem[6'(i)] = fillWord(i);
        end
        for (i = 0; i < 32; i++) begin
            modelRegs[5'(i)] = '0;
        end
        genProgram();
        runModel();
        nExpWrites = expWrPc.size();
        nExpStores = expStPc.size();

        repeat (ResetCycles) begin
            @(negedge clk);
            checkIdle(instrAddr, regWriteEn, dataByteen);
        end
        rstN = 1'b1;
        #1;
        checkIdle(instrAddr, regWriteEn, dataByteen);
        reportTest(0, "reset state");

        // Run until every expected retirement has been seen
        while (expWrPc.size() != 0 || expStPc.size() != 0) begin
            @(negedge clk);
        end
        repeat (DrainCycles) @(negedge clk);
        reportTest(1, "alu chains and forwarding");
        reportTest(2, "loads and stores");
        $display("branches taken %0d, untaken %0d, jal %0d", nTaken, nUntaken, nJal);
        reportTest(3, "branches and jal");

        checks++;
        if (seenWrites != nExpWrites || seenStores != nExpStores) begin
            $display("Error at %0t: saw %0d writes and %0d stores, expected %0d and %0d",
                     $time, seenWrites, seenStores, nExpWrites, nExpStores);
            errs[4]++;
        end
        for (i = 0; i < 64; i++) begin
            checks++;
            if (dmem[6'(i)] !== modelMem[6'(i)]) begin
                $display("Error at %0t: memory word %0d is %h, expected %h",
                         $time, i, dmem[6'(i)], modelMem[6'(i)]);
                errs[4]++;
            end
        end
        reportTest(4, "final counts and memory");

        total = errs[0] + errs[1] + errs[2] + errs[3] + errs[4];
        $display("%0d checks, %0d errors", checks, total);
        if (total == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/mipsCpu.sv
`timescale 1ns/1ps
`default_nettype none

module mipsCpu (
    input  wire logic             clk,
    input  wire logic             rstN,
    output mipsPkg::wordT         instrAddr,
    input  wire mipsPkg::wordT    instrRdata,
    output mipsPkg::wordT         dataAddr,
    output mipsPkg::wordT         dataWdata,
    output mipsPkg::wordT         dataPc,
    output logic [3:0]            dataByteen,
    input  wire mipsPkg::wordT    dataRdata,
    output logic                  regWriteEn,
    output mipsPkg::regAddrT      regWriteAddr,
    output mipsPkg::wordT         regWriteData,
    output mipsPkg::wordT         regWritePc
);
    import mipsPkg::*;

    // Decode
    wordT       instrD, pcD, rfRs, rfRt, rsFwdD, rtFwdD;
    logic       readsRs, readsRt, isBranchD, branchNeD, isJalD;
    stageCountT tUseRs, tUseRt, tNewD;
    regAddrT    destD;
    logic       stall;

    // Execute
    wordT       instrE, pcE, rsValueE, rtValueE, rsFwdE, rtFwdE, resultE;
    regAddrT    destE;
    stageCountT tNewE;
    aluOpT      aluOpE;
    logic       useImmE, signExtE, isJalE;

    // Memory
    wordT       instrM, rtValueM, resultM, rtFwdM;
    regAddrT    destM;
    stageCountT tNewM;
    logic       isLoadM, memWriteM;

    fetchUnit u_fetchUnit (
        .clk(clk), .rstN(rstN), .stall(stall),
        .isBranch(isBranchD), .branchNe(branchNeD), .isJal(isJalD),
        .rsValue(rsFwdD), .rtValue(rtFwdD), .instrRdata(instrRdata),
        .instrAddr(instrAddr), .instrD(instrD), .pcD(pcD)
    );

    regFile u_regFile (
        .clk(clk), .rstN(rstN), .instr(instrD),
        .writeAddr(regWriteAddr), .writeData(regWriteData),
        .rsValue(rfRs), .rtValue(rfRt)
    );

    instrDecoder decD (
        .instr(instrD), .readsRs(readsRs), .readsRt(readsRt),
        .tUseRs(tUseRs), .tUseRt(tUseRt), .tNew(tNewD), .dest(destD),
        .aluOp(), .useImm(), .signExt(),
        .isBranch(isBranchD), .branchNe(branchNeD), .isJal(isJalD),
        .isLoad(), .memWrite()
    );

    instrDecoder decE (
        .instr(instrE), .readsRs(), .readsRt(),
        .tUseRs(), .tUseRt(), .tNew(), .dest(),
        .aluOp(aluOpE), .useImm(useImmE), .signExt(signExtE),
        .isBranch(), .branchNe(), .isJal(isJalE),
        .isLoad(), .memWrite()
    );

    instrDecoder decM (
        .instr(instrM), .readsRs(), .readsRt(),
        .tUseRs(), .tUseRt(), .tNew(), .dest(),
        .aluOp(), .useImm(), .signExt(),
        .isBranch(), .branchNe(), .isJal(),
        .isLoad(isLoadM), .memWrite(memWriteM)
    );

    executeStage u_executeStage (
        .clk(clk), .rstN(rstN), .stall(stall),
        .instrD(instrD), .pcD(pcD), .rsValueD(rsFwdD), .rtValueD(rtFwdD),
        .destD(destD), .tNewD(tNewD),
        .aluOp(aluOpE), .useImm(useImmE), .signExt(signExtE), .isJal(isJalE),
        .rsFwd(rsFwdE), .rtFwd(rtFwdE),
        .instrE(instrE), .pcE(pcE), .rsValueE(rsValueE), .rtValueE(rtValueE),
        .destE(destE), .tNewE(tNewE), .resultE(resultE)
    );

    // Forwarded store data travels on into memory
    memWbStage u_memWbStage (
        .clk(clk), .rstN(rstN),
        .instrE(instrE), .pcE(pcE), .rtValueE(rtFwdE), .resultE(resultE),
        .destE(destE), .tNewE(tNewE),
        .isLoad(isLoadM), .memWrite(memWriteM),
        .rtFwdM(rtFwdM), .dataRdata(dataRdata),
        .instrM(instrM), .pcM(dataPc), .rtValueM(rtValueM), .resultM(resultM),
        .destM(destM), .tNewM(tNewM),
        .dataAddr(dataAddr), .dataWdata(dataWdata), .dataByteen(dataByteen),
        .regWriteEn(regWriteEn), .regWriteAddr(regWriteAddr),
        .regWriteData(regWriteData), .regWritePc(regWritePc)
    );

    hazardForward u_hazardForward (
        .instrD(instrD), .instrE(instrE), .instrM(instrM),
        .readsRs(readsRs), .readsRt(readsRt), .tUseRs(tUseRs), .tUseRt(tUseRt),
        .destE(destE), .destM(destM), .destW(regWriteAddr),
        .tNewE(tNewE), .tNewM(tNewM),
        .rfRs(rfRs), .rfRt(rfRt),
        .rsValueE(rsValueE), .rtValueE(rtValueE), .rtValueM(rtValueM),
        .resultE(resultE), .resultM(resultM), .resultW(regWriteData),
        .stall(stall),
        .rsFwdD(rsFwdD), .rtFwdD(rtFwdD), .rsFwdE(rsFwdE), .rtFwdE(rtFwdE),
        .rtFwdM(rtFwdM)
    );

endmodule

`default_nettype wire

//--- verilog/hazardForward.sv
`timescale 1ns/1ps
`default_nettype none

module hazardForward (
    input  wire mipsPkg::wordT       instrD,
    input  wire mipsPkg::wordT       instrE,
    input  wire mipsPkg::wordT       instrM,
    input  wire logic                readsRs,
    input  wire logic                readsRt,
    input  wire mipsPkg::stageCountT tUseRs,
    input  wire mipsPkg::stageCountT tUseRt,
    input  wire mipsPkg::regAddrT    destE,
    input  wire mipsPkg::regAddrT    destM,
    input  wire mipsPkg::regAddrT    destW,
    input  wire mipsPkg::stageCountT tNewE,
    input  wire mipsPkg::stageCountT tNewM,
    input  wire mipsPkg::wordT       rfRs,
    input  wire mipsPkg::wordT       rfRt,
    input  wire mipsPkg::wordT       rsValueE,
    input  wire mipsPkg::wordT       rtValueE,
    input  wire mipsPkg::wordT       rtValueM,
    input  wire mipsPkg::wordT       resultE,
    input  wire mipsPkg::wordT       resultM,
    input  wire mipsPkg::wordT       resultW,
    output logic                     stall,
    output mipsPkg::wordT            rsFwdD,
    output mipsPkg::wordT            rtFwdD,
    output mipsPkg::wordT            rsFwdE,
    output mipsPkg::wordT            rtFwdE,
    output mipsPkg::wordT            rtFwdM
);
    import mipsPkg::*;

    regAddrT rsD;
    regAddrT rtD;
    regAddrT rsE;
    regAddrT rtE;
    regAddrT rtM;
    logic    stallRs;
    logic    stallRt;

    assign rsD = instrD[25:21];
    assign rtD = instrD[20:16];
    assign rsE = instrE[25:21];
    assign rtE = instrE[20:16];
    assign rtM = instrM[20:16];

    // A result still in flight that the reader needs too early
    function automatic logic mustWait(regAddrT r, stageCountT tUse);
        return (r != '0) &&
               ((r == destE && tNewE > tUse) || (r == destM && tNewM > tUse));
    endfunction

    assign stallRs = readsRs && mustWait(rsD, tUseRs);
    assign stallRt = readsRt && mustWait(rtD, tUseRt);
    assign stall   = stallRs || stallRt;

    // Decode operands, nearest stage first
    function automatic wordT fwdDecode(regAddrT r, wordT rf);
        if (r == '0) begin
            return rf;
        end else if (r == destE && tNewE == 2'd0) begin
            return resultE;
        end else if (r == destM && tNewM == 2'd0) begin
            return resultM;
        end else if (r == destW) begin
            return resultW;
        end
        return rf;
    endfunction

    function automatic wordT fwdExecute(regAddrT r, wordT held);
        if (r == '0) begin
            return held;
        end else if (r == destM && tNewM == 2'd0) begin
            return resultM;
        end else if (r == destW) begin
            return resultW;
        end
        return held;
    endfunction

    assign rsFwdD = fwdDecode(rsD, rfRs);
    assign rtFwdD = fwdDecode(rtD, rfRt);
    assign rsFwdE = fwdExecute(rsE, rsValueE);
    assign rtFwdE = fwdExecute(rtE, rtValueE);

    // Store data behind a load in writeback
    assign rtFwdM = (rtM != '0 && rtM == destW) ? resultW : rtValueM;

endmodule

`default_nettype wire

//--- verilog/memWbStage.sv
`timescale 1ns/1ps
`default_nettype none

module memWbStage (
    input  wire logic                clk,
    input  wire logic                rstN,
    input  wire mipsPkg::wordT       instrE,
    input  wire mipsPkg::wordT       pcE,
    input  wire mipsPkg::wordT       rtValueE,
    input  wire mipsPkg::wordT       resultE,
    input  wire mipsPkg::regAddrT    destE,
    input  wire mipsPkg::stageCountT tNewE,
    input  wire logic                isLoad,
    input  wire logic                memWrite,
    input  wire mipsPkg::wordT       rtFwdM,
    input  wire mipsPkg::wordT       dataRdata,
    output mipsPkg::wordT            instrM,
    output mipsPkg::wordT            pcM,
    output mipsPkg::wordT            rtValueM,
    output mipsPkg::wordT            resultM,
    output mipsPkg::regAddrT         destM,
    output mipsPkg::stageCountT      tNewM,
    output mipsPkg::wordT            dataAddr,
    output mipsPkg::wordT            dataWdata,
    output logic [3:0]               dataByteen,
    output logic                     regWriteEn,
    output mipsPkg::regAddrT         regWriteAddr,
    output mipsPkg::wordT            regWriteData,
    output mipsPkg::wordT            regWritePc
);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            instrM       <= '0;
            destM        <= '0;
            tNewM        <= '0;
            regWriteAddr <= '0;
        end else begin
            instrM       <= instrE;
            destM        <= destE;
            // One stage closer to ready, floored at zero
            tNewM        <= (tNewE == 2'd0) ? 2'd0 : tNewE - 2'd1;
            regWriteAddr <= destM;
        end
    end

    always_ff @(posedge clk) begin
        pcM          <= pcE;
        rtValueM     <= rtValueE;
        resultM      <= resultE;
        regWritePc   <= pcM;
        regWriteData <= isLoad ? dataRdata : resultM;
    end

    // Word stores only
    assign dataAddr   = resultM;
    assign dataWdata  = rtFwdM;
    assign dataByteen = memWrite ? 4'hf : 4'h0;

    assign regWriteEn = (regWriteAddr != '0);

endmodule

`default_nettype wire

//--- verilog/executeStage.sv
`timescale 1ns/1ps
`default_nettype none

module executeStage (
    input  wire logic                clk,
    input  wire logic                rstN,
    input  wire logic                stall,
    input  wire mipsPkg::wordT       instrD,
    input  wire mipsPkg::wordT       pcD,
    input  wire mipsPkg::wordT       rsValueD,
    input  wire mipsPkg::wordT       rtValueD,
    input  wire mipsPkg::regAddrT    destD,
    input  wire mipsPkg::stageCountT tNewD,
    input  wire mipsPkg::aluOpT      aluOp,
    input  wire logic                useImm,
    input  wire logic                signExt,
    input  wire logic                isJal,
    input  wire mipsPkg::wordT       rsFwd,
    input  wire mipsPkg::wordT       rtFwd,
    output mipsPkg::wordT            instrE,
    output mipsPkg::wordT            pcE,
    output mipsPkg::wordT            rsValueE,
    output mipsPkg::wordT            rtValueE,
    output mipsPkg::regAddrT         destE,
    output mipsPkg::stageCountT      tNewE,
    output mipsPkg::wordT            resultE
);
    import mipsPkg::*;

    wordT immExt;
    wordT aluB;
    wordT aluOut;

    // Stall sends a nop bubble into execute
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            instrE <= '0;
            destE  <= '0;
            tNewE  <= '0;
        end else if (stall) begin
            instrE <= '0;
            destE  <= '0;
            tNewE  <= '0;
        end else begin
            instrE <= instrD;
            destE  <= destD;
            tNewE  <= tNewD;
        end
    end

    always_ff @(posedge clk) begin
        pcE      <= pcD;
        rsValueE <= rsValueD;
        rtValueE <= rtValueD;
    end

    // ori takes a zero-extended immediate
    assign immExt = signExt ? {{16{instrE[15]}}, instrE[15:0]} : {16'b0, instrE[15:0]};
    assign aluB   = useImm ? immExt : rtFwd;

    always_comb begin
        case (aluOp)
            aluSub:  aluOut = rsFwd - aluB;
            aluOr:   aluOut = rsFwd | aluB;
            aluSlt:  aluOut = {31'b0, $signed(rsFwd) < $signed(aluB)};
            aluLui:  aluOut = {aluB[15:0], 16'b0};
            default: aluOut = rsFwd + aluB;
        endcase
    end

    // Return address skips the delay slot
    assign resultE = isJal ? pcE + 32'd8 : aluOut;

endmodule

`default_nettype wire

//--- verilog/fetchUnit.sv
`timescale 1ns/1ps
`default_nettype none

`include "mipsDefines.svh"

module fetchUnit (
    input  wire logic          clk,
    input  wire logic          rstN,
    input  wire logic          stall,
    input  wire logic          isBranch,
    input  wire logic          branchNe,
    input  wire logic          isJal,
    input  wire mipsPkg::wordT rsValue,
    input  wire mipsPkg::wordT rtValue,
    input  wire mipsPkg::wordT instrRdata,
    output mipsPkg::wordT      instrAddr,
    output mipsPkg::wordT      instrD,
    output mipsPkg::wordT      pcD
);
    import mipsPkg::*;

    wordT pcPlus4D;
    wordT branchOffset;
    wordT nextPc;
    logic branchTaken;

    assign pcPlus4D     = pcD + 32'd4;
    assign branchOffset = {{14{instrD[15]}}, instrD[15:0], 2'b00};
    // bne inverts the equality result
    assign branchTaken  = isBranch && ((rsValue == rtValue) != branchNe);

    always_comb begin
        if (isJal) begin
            nextPc = {pcPlus4D[31:28], instrD[25:0], 2'b00};
        end else if (branchTaken) begin
            nextPc = pcPlus4D + branchOffset;
        end else begin
            nextPc = instrAddr + 32'd4;
        end
    end

    // PC and decode register hold together on a stall
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            instrAddr <= `MIPS_RESET_PC;
            instrD    <= '0;
            pcD       <= `MIPS_RESET_PC;
        end else if (!stall) begin
            instrAddr <= nextPc;
            instrD    <= instrRdata;
            pcD       <= instrAddr;
        end
    end

endmodule

`default_nettype wire

//--- verilog/regFile.sv
`timescale 1ns/1ps
`default_nettype none

`include "mipsDefines.svh"

module regFile (
    input  wire logic             clk,
    input  wire logic             rstN,
    input  wire mipsPkg::wordT    instr,
    input  wire mipsPkg::regAddrT writeAddr,
    input  wire mipsPkg::wordT    writeData,
    output mipsPkg::wordT         rsValue,
    output mipsPkg::wordT         rtValue
);
    import mipsPkg::*;

    localparam int NumRegs = 1 << `MIPS_REG_ADDR_WIDTH;

    wordT    regs [NumRegs];
    regAddrT rsAddr;
    regAddrT rtAddr;

    // Read addresses come straight from the decode instruction
    assign rsAddr  = instr[25:21];
    assign rtAddr  = instr[20:16];
    assign rsValue = (rsAddr == '0) ? '0 : regs[rsAddr];
    assign rtValue = (rtAddr == '0) ? '0 : regs[rtAddr];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            regs <= '{default: '0};
        end else if (writeAddr != '0) begin
            regs[writeAddr] <= writeData;
        end
    end

endmodule

`default_nettype wire

//--- verilog/instrDecoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "mipsDefines.svh"

module instrDecoder (
    input  wire mipsPkg::wordT       instr,
    output logic                     readsRs,
    output logic                     readsRt,
    output mipsPkg::stageCountT      tUseRs,
    output mipsPkg::stageCountT      tUseRt,
    output mipsPkg::stageCountT      tNew,
    output mipsPkg::regAddrT         dest,
    output mipsPkg::aluOpT           aluOp,
    output logic                     useImm,
    output logic                     signExt,
    output logic                     isBranch,
    output logic                     branchNe,
    output logic                     isJal,
    output logic                     isLoad,
    output logic                     memWrite
);
    import mipsPkg::*;

    logic [5:0] opcode;
    logic [5:0] funct;
    regAddrT    rtField;
    regAddrT    rdField;

    assign opcode  = instr[31:26];
    assign funct   = instr[5:0];
    assign rtField = instr[20:16];
    assign rdField = instr[15:11];

    always_comb begin
        logic rType;
        rType    = 1'b0;
        readsRs  = 1'b0;
        readsRt  = 1'b0;
        tUseRs   = 2'd0;
        tUseRt   = 2'd0;
        tNew     = 2'd0;
        dest     = '0;
        aluOp    = aluAdd;
        useImm   = 1'b0;
        signExt  = 1'b0;
        isBranch = 1'b0;
        branchNe = 1'b0;
        isJal    = 1'b0;
        isLoad   = 1'b0;
        memWrite = 1'b0;
        case (opcode)
            `MIPS_OP_SPECIAL: begin
                rType = 1'b1;
                case (funct)
                    `MIPS_FN_ADDU: aluOp = aluAdd;
                    `MIPS_FN_SUBU: aluOp = aluSub;
                    `MIPS_FN_OR:   aluOp = aluOr;
                    `MIPS_FN_SLT:  aluOp = aluSlt;
                    default:       rType = 1'b0;
                endcase
                if (rType) begin
                    readsRs = 1'b1;
                    readsRt = 1'b1;
                    tUseRs  = 2'd1;
                    tUseRt  = 2'd1;
                    dest    = rdField;
                    tNew    = 2'd1;
                end
            end
            `MIPS_OP_ORI: begin
                readsRs = 1'b1;
                tUseRs  = 2'd1;
                dest    = rtField;
                tNew    = 2'd1;
                aluOp   = aluOr;
                useImm  = 1'b1;
            end
            `MIPS_OP_LUI: begin
                dest   = rtField;
                tNew   = 2'd1;
                aluOp  = aluLui;
                useImm = 1'b1;
            end
            `MIPS_OP_LW: begin
                readsRs = 1'b1;
                tUseRs  = 2'd1;
                dest    = rtField;
                tNew    = 2'd2;
                useImm  = 1'b1;
                signExt = 1'b1;
                isLoad  = 1'b1;
            end
            `MIPS_OP_SW: begin
                // Store data is needed only once the store reaches memory
                readsRs  = 1'b1;
                readsRt  = 1'b1;
                tUseRs   = 2'd1;
                tUseRt   = 2'd2;
                useImm   = 1'b1;
                signExt  = 1'b1;
                memWrite = 1'b1;
            end
            `MIPS_OP_BEQ, `MIPS_OP_BNE: begin
                readsRs  = 1'b1;
                readsRt  = 1'b1;
                isBranch = 1'b1;
                branchNe = (opcode == `MIPS_OP_BNE);
            end
            `MIPS_OP_JAL: begin
                // Link value is ready as soon as execute sees it
                dest  = `MIPS_LINK_REG;
                isJal = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/mipsPkg.sv
`default_nettype none

`include "mipsDefines.svh"

package mipsPkg;

    // One data or address word
    typedef logic [`MIPS_DATA_WIDTH-1:0] wordT;

    // Register number
    typedef logic [`MIPS_REG_ADDR_WIDTH-1:0] regAddrT;

    // Stage count, used for both tUse and tNew
    typedef logic [1:0] stageCountT;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluOr,
        aluSlt,
        aluLui
    } aluOpT;

endpackage

`default_nettype wire

//--- verilog/mipsDefines.svh
`ifndef MIPS_DEFINES_SVH
`define MIPS_DEFINES_SVH

// Datapath widths
`define MIPS_DATA_WIDTH     32
`define MIPS_REG_ADDR_WIDTH 5

// First fetch address and the jal return register
`define MIPS_RESET_PC       32'h0000_3000
`define MIPS_LINK_REG       5'd31

// Primary opcodes
`define MIPS_OP_SPECIAL     6'b000000
`define MIPS_OP_ORI         6'b001101
`define MIPS_OP_LUI         6'b001111
`define MIPS_OP_LW          6'b100011
`define MIPS_OP_SW          6'b101011
`define MIPS_OP_BEQ         6'b000100
`define MIPS_OP_BNE         6'b000101
`define MIPS_OP_JAL         6'b000011

// Function codes under SPECIAL
`define MIPS_FN_ADDU        6'b100001
`define MIPS_FN_SUBU        6'b100011
`define MIPS_FN_OR          6'b100101
`define MIPS_FN_SLT         6'b101010

`endif
